/* data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module data_memory (
    input  wire                 clk,
    input  wire lsu_pkg::addr_t addr,
    input  wire                 we,
    input  wire lsu_pkg::byte_t wdata,
    output lsu_pkg::byte_t      rdata
);

    import lsu_pkg::*;

    localparam int DEPTH = 1 << `DMEM_ADDR_W;

    // upper address bits are dropped, so addresses alias.
    logic [`DMEM_ADDR_W-1:0] idx;

    byte_t mem [0:DEPTH-1];

    assign idx = addr[`DMEM_ADDR_W-1:0];

    // memory starts out cleared.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read-first: a read of the address being written returns the old byte.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
        rdata <= mem[idx];
    end

    // a write to an unknown address would corrupt an unknown byte.
    a_write_addr_known: assert property (
        @(posedge clk)
        we |-> !$isunknown(addr)
    ) else $error("data memory write with unknown address");

endmodule

`default_nettype wire

/* load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  wire                  clk,
    input  wire                  rst,

    // one operation per cycle from issue.
    input  wire lsu_pkg::mem_req_t req,
    input  wire                  req_valid,

    // completions, two edges after acceptance.
    output lsu_pkg::mem_result_t result,
    output logic                 result_valid
);

    import lsu_pkg::*;

    // memory port between pipeline and RAM.
    wire addr_t mem_addr;
    wire        mem_store;
    wire byte_t mem_wdata;
    wire byte_t mem_rdata;

    memory_pipeline u_pipeline (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .mem_addr     (mem_addr),
        .mem_store    (mem_store),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .result       (result),
        .result_valid (result_valid)
    );

    // private byte-wide data memory.
    data_memory u_dmem (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_store),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* lsu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_checker (
    input  wire                       clk,
    input  wire                       rst,
    input  wire lsu_pkg::mem_req_t    req,
    input  wire                       req_valid,
    input  wire lsu_pkg::mem_result_t result,
    input  wire                       result_valid,
    output int                        error_count,
    output int                        pending,
    output int                        result_count
);

    import lsu_pkg::*;

    localparam int MODEL_BYTES = 1 << `DMEM_ADDR_W;

    // one expected completion, in issue order.
    typedef struct packed {
        mem_tag_t    tag;
        byte_t       data;
        logic        store;
        logic [31:0] due;
    } expect_t;

    byte_t       model [0:MODEL_BYTES-1];
    expect_t     expect_q [$];
    logic [31:0] cycle;
    logic        armed;

    initial begin
        for (int i = 0; i < MODEL_BYTES; i++) begin
            model[i] = '0;
        end
        cycle        = 0;
        armed        = 1'b0;
        error_count  = 0;
        pending      = 0;
        result_count = 0;
    end

    // page-local keeps the high byte, full mode carries into it.
    function automatic addr_t effective_address(input mem_req_t r);
        logic [16:0] sum;
        if (r.imm[3]) begin
            return (r.base & 16'hff00) | ((r.base + r.offset) & 16'h00ff);
        end
        sum = r.base + r.offset;
        return sum[15:0];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error: %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic accept_request();
        addr_t   addr;
        expect_t e;
        addr    = effective_address(req);
        e.tag   = req.tag;
        e.store = req.opcode[0];
        e.data  = model[addr % MODEL_BYTES];
        e.due   = cycle + 2;
        // stores land at acceptance, so any later load sees them.
        if (e.store) begin
            model[addr % MODEL_BYTES] = req.data;
        end
        expect_q.push_back(e);
    endtask

    task automatic check_result();
        expect_t e;
        if (result_valid === 1'b1) begin
            result_count++;
            if (expect_q.size() == 0) begin
                error_count++;
                $display("result_valid high at cycle %0d with no request outstanding", cycle);
            end else begin
                e = expect_q.pop_front();
                if (e.due != cycle) begin
                    error_count++;
                    $display("result for rob entry %0h came at cycle %0d instead of %0d",
                             e.tag.rob_entry, cycle, e.due);
                end
                compare_value("result.tag.rob_entry", result.tag.rob_entry, e.tag.rob_entry);
                compare_value("result.tag.dest_reg", result.tag.dest_reg, e.tag.dest_reg);
                compare_value("result.tag.dest_arch", result.tag.dest_arch, e.tag.dest_arch);
                // store data field is the old byte and carries no meaning.
                if (!e.store) begin
                    compare_value("result.data", result.data, e.data);
                end
            end
        end else if (result_valid !== 1'b0) begin
            error_count++;
            $display("error: result_valid got %h expected 0 or 1", result_valid);
        end else if (expect_q.size() != 0 && expect_q[0].due <= cycle) begin
            e = expect_q.pop_front();
            error_count++;
            $display("no result for rob entry %0h, due at cycle %0d", e.tag.rob_entry, e.due);
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (armed) begin
            check_result();
        end
        if (rst) begin
            armed = 1'b1;
        end else if (armed && req_valid === 1'b1) begin
            accept_request();
        end
        pending = expect_q.size();
    end

endmodule

`default_nettype wire

/* lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// byte address and data byte widths.
`define LSU_ADDR_W 16
`define LSU_DATA_W 8

// tag field widths.
`define LSU_ROB_W 5
`define PR_ADDR_W 6
`define LSU_AREG_W 4

// request control fields.
`define LSU_OP_W 4
`define LSU_IMM_W 4

// opcode bit for a store, imm bit for page-local addressing.
`define LSU_STORE_BIT 0
`define LSU_PAGE_BIT 3

// 1024 bytes of data memory.
`define DMEM_ADDR_W 10

`endif

/* lsu_pkg.sv */
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

    // plain vector types.
    typedef logic [`LSU_ADDR_W-1:0] addr_t;
    typedef logic [`LSU_DATA_W-1:0] byte_t;
    typedef logic [`LSU_DATA_W-1:0] offset_t;
    typedef logic [`LSU_ROB_W-1:0]  rob_idx_t;
    typedef logic [`PR_ADDR_W-1:0]  preg_t;
    typedef logic [`LSU_AREG_W-1:0] areg_t;
    typedef logic [`LSU_OP_W-1:0]   opcode_t;
    typedef logic [`LSU_IMM_W-1:0]  imm_t;

    // writeback identity, carried through the pipeline untouched.
    typedef struct packed {
        rob_idx_t rob_entry;
        preg_t    dest_reg;
        areg_t    dest_arch;
    } mem_tag_t;

    // one memory operation from issue.
    typedef struct packed {
        opcode_t  opcode;
        addr_t    base;
        offset_t  offset;
        imm_t     imm;
        byte_t    data;
        mem_tag_t tag;
    } mem_req_t;

    // completion toward writeback.
    // data is the old memory byte for a store.
    typedef struct packed {
        mem_tag_t tag;
        byte_t    data;
    } mem_result_t;

endpackage

`default_nettype wire

/* memory_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module memory_pipeline (
    input  wire                  clk,
    input  wire                  rst,

    // issue side.
    input  wire lsu_pkg::mem_req_t req,
    input  wire                  req_valid,

    // data memory port.
    output lsu_pkg::addr_t       mem_addr,
    output logic                 mem_store,
    output lsu_pkg::byte_t       mem_wdata,
    input  wire lsu_pkg::byte_t  mem_rdata,

    // writeback side.
    output lsu_pkg::mem_result_t result,
    output logic                 result_valid
);

    import lsu_pkg::*;

    // decoded request fields.
    logic     req_store;
    logic     req_page;

    // address arithmetic.
    byte_t    page_low;
    addr_t    full_addr;
    addr_t    next_addr;

    // stage one, operation in flight at the memory.
    mem_tag_t inflight_tag;
    logic     inflight_valid;

    // stage two, completion.
    mem_tag_t out_tag;

    assign req_store = req.opcode[`LSU_STORE_BIT];
    assign req_page  = req.imm[`LSU_PAGE_BIT];

    // page-local wraps in the low byte, no carry out.
    assign page_low  = req.base[`LSU_DATA_W-1:0] + req.offset;
    assign full_addr = req.base + addr_t'(req.offset);

    always_comb begin
        if (req_page) begin
            next_addr = {req.base[`LSU_ADDR_W-1:`LSU_DATA_W], page_low};
        end else begin
            next_addr = full_addr;
        end
    end

    // stage one payload.
    always_ff @(posedge clk) begin
        mem_addr     <= next_addr;
        mem_wdata    <= req.data;
        inflight_tag <= req.tag;
    end

    // stage one control.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_store      <= 1'b0;
            inflight_valid <= 1'b0;
        end else begin
            // every valid request is taken, no refusal.
            mem_store      <= req_valid & req_store;
            inflight_valid <= req_valid;
        end
    end

    // stage two payload, memory writes or reads on this same edge.
    always_ff @(posedge clk) begin
        out_tag <= inflight_tag;
    end

    // stage two control.
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= inflight_valid;
        end
    end

    // read byte comes straight from the RAM output register.
    assign result.tag  = out_tag;
    assign result.data = mem_rdata;

    // a completion needs an operation in flight one edge earlier.
    a_result_follows_inflight: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |-> $past(inflight_valid)
    ) else $error("result_valid without an operation in flight");

    // the RAM write strobe belongs to a live operation.
    a_store_needs_inflight: assert property (
        @(posedge clk) disable iff (rst)
        mem_store |-> inflight_valid
    ) else $error("mem_store high with no operation in flight");

endmodule

`default_nettype wire

/* project.f */
+incdir+.
lsu_pkg.sv
memory_pipeline.sv
data_memory.sv
load_store_unit.sv
lsu_checker.sv
tb_load_store_unit.sv

/* tb_load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_load_store_unit;

    import lsu_pkg::*;

    localparam int NUM_REQS       = 2000;
    localparam int VALID_PCT      = 70;
    localparam int PAIR_EVERY     = 8;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 100 / VALID_PCT + 100;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    logic        req_valid;
    mem_result_t result;
    logic        result_valid;

    int          error_count;
    int          pending;
    int          result_count;
    int          run_errors;
    int          issued;
    int          cycles;
    integer      seed;
    mem_req_t    pair_store;
    logic        pair_due;
    addr_t       base_pool [0:7];

    load_store_unit uut (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    lsu_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .result       (result),
        .result_valid (result_valid),
        .error_count  (error_count),
        .pending      (pending),
        .result_count (result_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // few bases, some near a byte boundary, several aliasing mod 1024.
    initial begin
        base_pool[0] = 16'h0000;
        base_pool[1] = 16'h00f8;
        base_pool[2] = 16'h01fe;
        base_pool[3] = 16'h02c0;
        base_pool[4] = 16'h03ff;
        base_pool[5] = 16'h12f0;
        base_pool[6] = 16'h4480;
        base_pool[7] = 16'hfff4;
    end

    task automatic make_random_req(output mem_req_t r);
        logic [31:0] rnd;
        logic [31:0] rnd_tag;
        rnd              = $random(seed);
        rnd_tag          = $random(seed);
        r.opcode         = rnd[3:0];
        r.base           = base_pool[rnd[6:4]];
        r.offset         = rnd[15:8];
        r.imm            = rnd[19:16];
        r.data           = rnd[27:20];
        r.tag.rob_entry  = rnd_tag[4:0];
        r.tag.dest_reg   = rnd_tag[8 +: $bits(preg_t)];
        r.tag.dest_arch  = rnd_tag[19:16];
    endtask

    task automatic drive_cycle();
        logic [31:0] rnd;
        mem_req_t    r;
        make_random_req(r);
        if (pair_due) begin
            // load right behind the store, same address.
            r.base      = pair_store.base;
            r.offset    = pair_store.offset;
            r.imm       = pair_store.imm;
            r.opcode[0] = 1'b0;
            pair_due    = 1'b0;
            req        <= r;
            req_valid  <= 1'b1;
            issued++;
        end else begin
            rnd = $random(seed);
            if (rnd % 100 < VALID_PCT) begin
                if (issued % PAIR_EVERY == 0) begin
                    r.opcode[0] = 1'b1;
                    pair_store  = r;
                    pair_due    = 1'b1;
                end
                req       <= r;
                req_valid <= 1'b1;
                issued++;
            end else begin
                req       <= r;
                req_valid <= 1'b0;
            end
        end
    endtask

    task automatic report_run(input logic timed_out);
        $display("requests %0d  results %0d  errors %0d", issued, result_count,
                 error_count + run_errors);
        if (timed_out || error_count != 0 || run_errors != 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
    endtask

    initial begin
        seed       = 32'h8ad0;
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        issued     = 0;
        run_errors = 0;
        pair_due   = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // idle cycles right after reset must stay quiet.
        repeat (2) @(posedge clk);
        while (issued < NUM_REQS) begin
            @(posedge clk);
            drive_cycle();
        end
        @(posedge clk);
        req_valid <= 1'b0;
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (result_count != issued) begin
            run_errors++;
            $display("saw %0d results for %0d accepted requests", result_count, issued);
        end
        report_run(1'b0);
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_run(1'b1);
        $finish;
    end

endmodule

`default_nettype wire
